/* common/mem_pkg.sv */
//****************************************
// memory stage pipeline types
//****************************************
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [1:0] {
        mem_op_none,
        mem_op_load,
        mem_op_store
    } mem_op_t;

    // item handed over by the execute stage
    typedef struct packed {
        addr_t     pc;
        data_t     alu_result;
        data_t     store_data;
        strb_t     store_strb;
        reg_addr_t reg_waddr;
        logic [3:0] reg_we;
        logic      mem_to_reg;
        mem_op_t   op;
    } exe_mem_t;

    typedef struct packed {
        addr_t     pc;
        data_t     alu_result;
        reg_addr_t reg_waddr;
        logic [3:0] reg_we;
        logic      mem_to_reg;
        data_t     load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* common/axi_pkg.sv */
//****************************************
// data bus channel types
//****************************************
`default_nettype none

package axi_pkg;

    typedef logic [3:0] axi_id_t;
    typedef logic [2:0] axi_size_t;

    // 4-byte beats only
    localparam axi_size_t axi_size_word = 3'd2;

    // all loads share one read id
    localparam axi_id_t load_id = 4'd1;

    typedef struct packed {
        axi_id_t        id;
        mem_pkg::addr_t addr;
        axi_size_t      size;
    } ar_t;

    typedef struct packed {
        axi_id_t        id;
        mem_pkg::addr_t addr;
        axi_size_t      size;
    } aw_t;

    typedef struct packed {
        axi_id_t        id;
        mem_pkg::data_t data;
        mem_pkg::strb_t strb;
    } w_t;

    typedef struct packed {
        axi_id_t        id;
        mem_pkg::data_t data;
    } r_t;

    typedef struct packed {
        axi_id_t id;
    } b_t;

endpackage

`default_nettype wire

/* source/mem_pipe_reg.sv */
//****************************************
// stage register and writeback latch
//****************************************
`default_nettype none

module mem_pipe_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              exe_valid,
    output logic              mem_allowin,
    input  mem_pkg::exe_mem_t exe_data,
    input  logic              load_done,
    input  mem_pkg::data_t    load_data,
    input  logic              store_done,
    output logic              stage_valid,
    output mem_pkg::exe_mem_t stage_data,
    output logic              advance,
    output logic              wb_valid,
    input  logic              wb_allowin,
    output mem_pkg::mem_wb_t  wb_data
);
    import mem_pkg::*;

    logic ready_go;

    // done levels only come up for the matching op
    assign ready_go    = (stage_data.op == mem_op_none) || load_done || store_done;
    assign wb_valid    = stage_valid && ready_go;
    assign advance     = wb_valid && wb_allowin;
    assign mem_allowin = !stage_valid || (ready_go && wb_allowin);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (mem_allowin) begin
            stage_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && mem_allowin) begin
            stage_data <= exe_data;
        end
    end

    // wb_data holds the item that last moved on to writeback
    always_ff @(posedge clk) begin
        if (advance) begin
            wb_data.pc         <= stage_data.pc;
            wb_data.alu_result <= stage_data.alu_result;
            wb_data.reg_waddr  <= stage_data.reg_waddr;
            wb_data.reg_we     <= stage_data.reg_we;
            wb_data.mem_to_reg <= stage_data.mem_to_reg;
            if (stage_data.op == mem_op_load) begin
                wb_data.load_data <= load_data;
            end else begin
                wb_data.load_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* load/load_issue.sv */
//****************************************
// load request FSM
//****************************************
`default_nettype none

module load_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              stage_valid,
    input  mem_pkg::exe_mem_t stage_data,
    input  logic              advance,
    input  logic              hazard,
    output logic              ar_valid,
    input  logic              ar_ready,
    output axi_pkg::ar_t      ar,
    input  logic              r_valid,
    output logic              r_ready,
    input  axi_pkg::r_t       r,
    output logic              load_done,
    output mem_pkg::data_t    load_data
);
    import mem_pkg::*;
    import axi_pkg::*;

    typedef enum logic [2:0] {
        idle,
        wait_hazard,
        addr,
        data,
        done
    } load_state_t;

    load_state_t state;
    logic        want;
    logic        r_hit;

    assign want  = stage_valid && (stage_data.op == mem_op_load);
    assign r_hit = r_valid && r_ready && (r.id == load_id);

    assign ar_valid  = (state == addr);
    assign r_ready   = (state == data);
    assign load_done = (state == done);

    assign ar.id   = load_id;
    assign ar.addr = {stage_data.alu_result[31:2], 2'b00};
    assign ar.size = axi_size_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (want) begin
                        // hold off while a store to this word is still in flight
                        state <= hazard ? wait_hazard : addr;
                    end
                end
                wait_hazard: if (!hazard) state <= addr;
                addr: if (ar_ready) state <= data;
                data: if (r_hit) state <= done;
                done: if (advance) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_hit) begin
            load_data <= r.data;
        end
    end

endmodule

`default_nettype wire

/* store/store_issue.sv */
//****************************************
// store request FSM
//****************************************
`default_nettype none

module store_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              stage_valid,
    input  mem_pkg::exe_mem_t stage_data,
    input  logic              advance,
    input  logic              slot_free,
    input  axi_pkg::axi_id_t  alloc_id,
    output logic              alloc,
    output logic              aw_valid,
    input  logic              aw_ready,
    output axi_pkg::aw_t      aw,
    output logic              w_valid,
    input  logic              w_ready,
    output axi_pkg::w_t       w,
    output logic              store_done
);
    import mem_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_slot,
        send,
        done
    } store_state_t;

    store_state_t state;
    logic         want;
    logic         aw_sent;
    logic         w_sent;
    logic         aw_fire;
    logic         w_fire;
    logic         both_sent;
    axi_id_t      issue_id;

    assign want      = stage_valid && (stage_data.op == mem_op_store);
    assign alloc     = slot_free && (((state == idle) && want) || (state == wait_slot));
    assign aw_valid  = (state == send) && !aw_sent;
    assign w_valid   = (state == send) && !w_sent;
    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    // beats may land in either order or together
    assign both_sent = (aw_sent || aw_fire) && (w_sent || w_fire);

    assign store_done = (state == done);

    assign aw.id   = issue_id;
    assign aw.addr = {stage_data.alu_result[31:2], 2'b00};
    assign aw.size = axi_size_word;
    assign w.id    = issue_id;
    assign w.data  = stage_data.store_data;
    assign w.strb  = stage_data.store_strb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (alloc) begin
                        state <= send;
                    end else if (want) begin
                        state <= wait_slot;
                    end
                end
                wait_slot: if (alloc) state <= send;
                send: if (both_sent) state <= done;
                done: if (advance) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (alloc) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_sent <= 1'b1;
            end
            if (w_fire) begin
                w_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            issue_id <= alloc_id;
        end
    end

endmodule

`default_nettype wire

/* store/store_table.sv */
//****************************************
// outstanding store slots
//****************************************
`default_nettype none

module store_table #(
    parameter int num_store_ids = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc,
    output axi_pkg::axi_id_t alloc_id,
    output logic             slot_free,
    input  mem_pkg::addr_t   store_addr,
    input  mem_pkg::addr_t   load_addr,
    input  logic             b_valid,
    input  axi_pkg::b_t      b,
    output logic             hazard
);
    import mem_pkg::*;
    import axi_pkg::*;

    localparam int idx_w = $clog2(num_store_ids);

    logic [num_store_ids-1:0] busy;
    logic [num_store_ids-1:0] match;
    addr_t                    slot_addr [num_store_ids];
    logic [idx_w-1:0]         free_idx;

    // lowest free slot wins, so scan from the top down
    always_comb begin
        free_idx = '0;
        for (int i = num_store_ids - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = idx_w'(i);
            end
        end
    end

    assign alloc_id  = axi_id_t'(free_idx);
    assign slot_free = ~&busy;

    always_comb begin
        for (int i = 0; i < num_store_ids; i++) begin
            match[i] = busy[i] && (slot_addr[i][31:2] == load_addr[31:2]);
        end
    end

    assign hazard = |match;

    // a response and a new store never target the same slot
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < num_store_ids; i++) begin
                if (b_valid && (b.id == axi_id_t'(i))) begin
                    busy[i] <= 1'b0;
                end
                if (alloc && (free_idx == idx_w'(i))) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_addr[free_idx] <= store_addr;
        end
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
//****************************************
// memory stage top
//****************************************
`default_nettype none

module mem_stage #(
    parameter int num_store_ids = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exe_valid,
    output logic              mem_allowin,
    input  mem_pkg::exe_mem_t exe_data,
    output logic              wb_valid,
    input  logic              wb_allowin,
    output mem_pkg::mem_wb_t  wb_data,
    output logic              ar_valid,
    input  logic              ar_ready,
    output axi_pkg::ar_t      ar,
    input  logic              r_valid,
    output logic              r_ready,
    input  axi_pkg::r_t       r,
    output logic              aw_valid,
    input  logic              aw_ready,
    output axi_pkg::aw_t      aw,
    output logic              w_valid,
    input  logic              w_ready,
    output axi_pkg::w_t       w,
    input  logic              b_valid,
    output logic              b_ready,
    input  axi_pkg::b_t       b
);
    import mem_pkg::*;
    import axi_pkg::*;

    logic     stage_valid;
    exe_mem_t stage_data;
    logic     advance;
    logic     load_done;
    data_t    load_data;
    logic     store_done;
    logic     alloc;
    logic     slot_free;
    axi_id_t  alloc_id;
    logic     hazard;

    // responses are never stalled
    assign b_ready = 1'b1;

    mem_pipe_reg u_pipe_reg (
        .clk         (clk),
        .rst         (rst),
        .exe_valid   (exe_valid),
        .mem_allowin (mem_allowin),
        .exe_data    (exe_data),
        .load_done   (load_done),
        .load_data   (load_data),
        .store_done  (store_done),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .advance     (advance),
        .wb_valid    (wb_valid),
        .wb_allowin  (wb_allowin),
        .wb_data     (wb_data)
    );

    load_issue u_load_issue (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .advance     (advance),
        .hazard      (hazard),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .load_done   (load_done),
        .load_data   (load_data)
    );

    store_issue u_store_issue (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage_data  (stage_data),
        .advance     (advance),
        .slot_free   (slot_free),
        .alloc_id    (alloc_id),
        .alloc       (alloc),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w           (w),
        .store_done  (store_done)
    );

    store_table #(
        .num_store_ids (num_store_ids)
    ) u_store_table (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_id   (alloc_id),
        .slot_free  (slot_free),
        .store_addr (stage_data.alu_result),
        .load_addr  (stage_data.alu_result),
        .b_valid    (b_valid),
        .b          (b),
        .hazard     (hazard)
    );

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
//****************************************
// bus memory slave model
//****************************************
`default_nettype none

module axi_mem_model (
    input  logic         clk,
    input  logic         rst,
    input  logic         hold_b,
    input  logic         ar_valid,
    output logic         ar_ready,
    input  axi_pkg::ar_t ar,
    output logic         r_valid,
    input  logic         r_ready,
    output axi_pkg::r_t  r,
    input  logic         aw_valid,
    output logic         aw_ready,
    input  axi_pkg::aw_t aw,
    input  logic         w_valid,
    output logic         w_ready,
    input  axi_pkg::w_t  w,
    output logic         b_valid,
    input  logic         b_ready,
    output axi_pkg::b_t  b
);
    import mem_pkg::*;
    import axi_pkg::*;

    data_t       mem [64];
    logic        rd_pend;
    ar_t         rd_req;
    ar_t         ar_beat;
    aw_t         aw_beat;
    w_t          w_beat;
    logic        ar_fire;
    logic        r_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic [15:0] aw_got;
    logic [15:0] w_got;
    addr_t       wr_addr [16];
    data_t       wr_data [16];
    strb_t       wr_strb [16];
    logic [3:0]  wr_delay [16];
    logic [31:0] rnd;
    int          seed;
    int          pick;

    initial begin
        seed = 84137;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0203);
        end
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        b_valid  = 1'b0;
        r        = '0;
        b        = '0;
        rd_pend  = 1'b0;
        aw_got   = '0;
        w_got    = '0;
        forever begin
            // handshakes seen here transfer on the coming edge
            @(negedge clk);
            ar_fire = ar_valid && ar_ready;
            r_fire  = r_valid && r_ready;
            aw_fire = aw_valid && aw_ready;
            w_fire  = w_valid && w_ready;
            b_fire  = b_valid && b_ready;
            ar_beat = ar;
            aw_beat = aw;
            w_beat  = w;
            @(posedge clk);
            #1;
            rnd = $random(seed);
            if (rst) begin
                r_valid = 1'b0;
                b_valid = 1'b0;
                rd_pend = 1'b0;
                aw_got  = '0;
                w_got   = '0;
            end else begin
                if (r_fire) begin
                    r_valid = 1'b0;
                end
                if (ar_fire) begin
                    rd_pend = 1'b1;
                    rd_req  = ar_beat;
                end
                // read latency is a coin flip per cycle
                if (rd_pend && !r_valid && rnd[0]) begin
                    r_valid = 1'b1;
                    r.id    = rd_req.id;
                    r.data  = mem[rd_req.addr[7:2]];
                    rd_pend = 1'b0;
                end
                if (aw_fire) begin
                    aw_got[aw_beat.id]   = 1'b1;
                    wr_addr[aw_beat.id]  = aw_beat.addr;
                    wr_delay[aw_beat.id] = rnd[7:4];
                end
                if (w_fire) begin
                    w_got[w_beat.id]   = 1'b1;
                    wr_data[w_beat.id] = w_beat.data;
                    wr_strb[w_beat.id] = w_beat.strb;
                end
                if (b_fire) begin
                    b_valid = 1'b0;
                end
                // random delays per id give out of order responses
                pick = -1;
                for (int i = 0; i < 16; i++) begin
                    if (aw_got[i] && w_got[i]) begin
                        if (wr_delay[i] != 4'd0) begin
                            wr_delay[i] = wr_delay[i] - 4'd1;
                        end else if (!hold_b && !b_valid && pick < 0) begin
                            pick = i;
                        end
                    end
                end
                if (pick >= 0) begin
                    b_valid = 1'b1;
                    b.id    = axi_id_t'(pick);
                    for (int k = 0; k < 4; k++) begin
                        if (wr_strb[pick][k]) begin
                            mem[wr_addr[pick][7:2]][8*k +: 8] = wr_data[pick][8*k +: 8];
                        end
                    end
                    aw_got[pick] = 1'b0;
                    w_got[pick]  = 1'b0;
                end
            end
            ar_ready = rnd[8] | rnd[9];
            aw_ready = rnd[10] | rnd[11];
            w_ready  = rnd[12] | rnd[13];
        end
    end

endmodule

`default_nettype wire

/* verif/tb_mem_stage.sv */
//****************************************
// memory stage testbench
//****************************************
`default_nettype none

module tb_mem_stage;
    import mem_pkg::*;
    import axi_pkg::*;

    localparam int num_ids = 4;

    logic        clk;
    logic        rst;
    logic        exe_valid;
    logic        mem_allowin;
    exe_mem_t    exe_data;
    logic        wb_valid;
    logic        wb_allowin;
    mem_wb_t     wb_data;
    logic        ar_valid;
    logic        ar_ready;
    ar_t         ar;
    logic        r_valid;
    logic        r_ready;
    r_t          r;
    logic        aw_valid;
    logic        aw_ready;
    aw_t         aw;
    logic        w_valid;
    logic        w_ready;
    w_t          w;
    logic        b_valid;
    logic        b_ready;
    b_t          b;
    logic        hold_b;

    int          seed;
    int          stall_seed;
    logic [31:0] rnd;
    logic [31:0] stall_bits;
    data_t       wdata;
    string       test_name;
    addr_t       pc_next;
    exe_mem_t    sent_q [$];
    exe_mem_t    retired;
    mem_wb_t     held_wb;
    logic        check_retired;
    logic        stall_prev;
    logic        aw_seen;
    logic        w_seen;
    axi_id_t     aw_id;
    axi_id_t     w_id;
    logic [15:0] in_use;
    addr_t       use_addr [16];
    data_t       exp_load;
    data_t       retired_load;
    data_t       last_load;
    int          ar_count;
    int          aw_count;
    int          base;
    int          n;

    mem_stage #(
        .num_store_ids (num_ids)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .exe_valid   (exe_valid),
        .mem_allowin (mem_allowin),
        .exe_data    (exe_data),
        .wb_valid    (wb_valid),
        .wb_allowin  (wb_allowin),
        .wb_data     (wb_data),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w           (w),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b           (b)
    );

    axi_mem_model mem_model (
        .clk      (clk),
        .rst      (rst),
        .hold_b   (hold_b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual == expected) else begin
            abort_run($sformatf("ERR %s %s expected %h actual %h",
                                test_name, name, expected, actual));
        end
    endtask

    task automatic require_that(input logic cond, input string msg);
        assert (cond) else begin
            abort_run($sformatf("%s: %s", test_name, msg));
        end
    endtask

    function automatic mem_op_t random_op(input logic [31:0] bits);
        case (bits % 32'd3)
            32'd0: return mem_op_none;
            32'd1: return mem_op_load;
            default: return mem_op_store;
        endcase
    endfunction

    // presents one item and returns once the stage has taken it
    task automatic send_item(input mem_op_t op, input int word, input data_t data,
                             input strb_t strb);
        logic [31:0] bits;
        logic        taken;
        int          cycles;
        bits = $random(seed);
        exe_data.pc         = pc_next;
        exe_data.alu_result = (word * 4) | {30'd0, bits[1:0]};
        exe_data.store_data = data;
        exe_data.store_strb = strb;
        exe_data.reg_waddr  = bits[8:4];
        exe_data.reg_we     = bits[12:9];
        exe_data.mem_to_reg = bits[13];
        exe_data.op         = op;
        exe_valid = 1'b1;
        pc_next = pc_next + 32'd4;
        cycles = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = mem_allowin;
            cycles++;
            require_that(cycles < 1000, "timeout waiting for mem_allowin");
            @(posedge clk);
            #2;
        end
        exe_valid = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (sent_q.size() != 0 || in_use != '0 || check_retired) begin
            @(negedge clk);
            cycles++;
            require_that(cycles < 2000, "timeout waiting for the pipeline to drain");
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    // writeback back-pressure, about one cycle in four
    initial begin
        stall_seed = 84137;
        wb_allowin = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            stall_bits = $random(stall_seed);
            wb_allowin = (stall_bits[1:0] != 2'd0);
        end
    end

    // scoreboard, sampled mid-cycle where all signals are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (ar_valid && ar_ready) begin
                require_that(sent_q.size() > 0 && sent_q[0].op == mem_op_load,
                             "read request without a load in the stage");
                expect_equal("ar addr", sent_q[0].alu_result & 32'hffff_fffc, ar.addr);
                expect_equal("ar id", 32'(load_id), 32'(ar.id));
                expect_equal("ar size", 32'd2, 32'(ar.size));
                for (int i = 0; i < 16; i++) begin
                    require_that(!(in_use[i] && use_addr[i][31:2] == ar.addr[31:2]),
                                 "load read a word with a store still in flight");
                end
                exp_load = mem_model.mem[ar.addr[7:2]];
                ar_count++;
            end
            if (aw_valid && aw_ready) begin
                require_that(sent_q.size() > 0 && sent_q[0].op == mem_op_store,
                             "write request without a store in the stage");
                expect_equal("aw addr", sent_q[0].alu_result & 32'hffff_fffc, aw.addr);
                expect_equal("aw size", 32'd2, 32'(aw.size));
                require_that(32'(aw.id) < num_ids, "write id out of range");
                require_that(!in_use[aw.id], "write id reused before its response");
                in_use[aw.id] = 1'b1;
                use_addr[aw.id] = aw.addr;
                aw_id = aw.id;
                aw_seen = 1'b1;
                aw_count++;
            end
            if (w_valid && w_ready) begin
                require_that(sent_q.size() > 0 && sent_q[0].op == mem_op_store,
                             "write data without a store in the stage");
                expect_equal("w data", sent_q[0].store_data, w.data);
                expect_equal("w strb", 32'(sent_q[0].store_strb), 32'(w.strb));
                w_id = w.id;
                w_seen = 1'b1;
            end
            if (b_valid && b_ready) begin
                in_use[b.id] = 1'b0;
            end
            // wb_data is loaded on the edge after the handover
            if (check_retired) begin
                expect_equal("wb pc", retired.pc, wb_data.pc);
                expect_equal("wb alu_result", retired.alu_result, wb_data.alu_result);
                expect_equal("wb reg_waddr", 32'(retired.reg_waddr), 32'(wb_data.reg_waddr));
                expect_equal("wb reg_we", 32'(retired.reg_we), 32'(wb_data.reg_we));
                expect_equal("wb mem_to_reg", 32'(retired.mem_to_reg),
                             32'(wb_data.mem_to_reg));
                if (retired.op == mem_op_load) begin
                    expect_equal("load data", retired_load, wb_data.load_data);
                    last_load = wb_data.load_data;
                end
                check_retired = 1'b0;
            end
            if (stall_prev) begin
                require_that(wb_valid, "wb_valid dropped while writeback stalled");
                require_that(wb_data == held_wb, "wb_data changed while writeback stalled");
            end
            stall_prev = wb_valid && !wb_allowin;
            held_wb = wb_data;
            if (wb_valid && wb_allowin) begin
                require_that(sent_q.size() > 0, "item reached writeback but was never sent");
                retired = sent_q.pop_front();
                if (retired.op == mem_op_store) begin
                    require_that(aw_seen && w_seen, "store released before both beats");
                    expect_equal("w id against aw id", 32'(aw_id), 32'(w_id));
                end
                retired_load = exp_load;
                aw_seen = 1'b0;
                w_seen = 1'b0;
                check_retired = 1'b1;
            end
            if (exe_valid && mem_allowin) begin
                sent_q.push_back(exe_data);
            end
        end
    end

    initial begin
        seed = 84137;
        rst = 1'b1;
        exe_valid = 1'b0;
        exe_data = '0;
        hold_b = 1'b0;
        pc_next = 32'h0040_0000;
        check_retired = 1'b0;
        stall_prev = 1'b0;
        aw_seen = 1'b0;
        w_seen = 1'b0;
        in_use = '0;
        ar_count = 0;
        aw_count = 0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        require_that(!wb_valid && !ar_valid && !r_ready && !aw_valid && !w_valid,
                     "a valid or ready output is high after reset");
        require_that(mem_allowin, "mem_allowin is low after reset");
        @(posedge clk);
        #2;

        test_name = "random";
        for (int k = 0; k < 300; k++) begin
            rnd = $random(seed);
            wdata = $random(seed);
            send_item(random_op(rnd), int'(rnd[5:3]), wdata, rnd[11:8]);
            if (rnd[15:14] == 2'd0) begin
                @(posedge clk);
                #2;
            end
        end
        drain();

        // a load behind a store to the same word waits for the response
        test_name = "hazard";
        hold_b = 1'b1;
        send_item(mem_op_store, 3, 32'h5eed_f00d, 4'hf);
        send_item(mem_op_load, 3, 32'h0, 4'h0);
        base = ar_count;
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            expect_equal("read requests while store held", base, ar_count);
        end
        @(posedge clk);
        #2;
        hold_b = 1'b0;
        drain();
        expect_equal("load after held store", 32'h5eed_f00d, last_load);

        test_name = "held_responses";
        hold_b = 1'b1;
        base = aw_count;
        for (int i = 0; i < num_ids + 1; i++) begin
            wdata = $random(seed);
            send_item(mem_op_store, 16 + i, wdata, 4'hf);
        end
        n = 0;
        while (aw_count != base + num_ids) begin
            @(negedge clk);
            n++;
            require_that(n < 500, "timeout waiting for the held stores to reach the bus");
        end
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            expect_equal("stores on the bus", base + num_ids, aw_count);
        end
        @(posedge clk);
        #2;
        hold_b = 1'b0;
        n = 0;
        while (aw_count != base + num_ids + 1) begin
            @(negedge clk);
            n++;
            require_that(n < 500, "timeout waiting for the blocked store to issue");
        end
        @(posedge clk);
        #2;
        drain();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/mem_pkg.sv
common/axi_pkg.sv
source/mem_pipe_reg.sv
load/load_issue.sv
store/store_issue.sv
store/store_table.sv
source/mem_stage.sv
verif/axi_mem_model.sv
verif/tb_mem_stage.sv

/* Makefile */
TOP = tb_mem_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f
	verilator --lint-only --top-module mem_stage common/mem_pkg.sv common/axi_pkg.sv \
		source/mem_pipe_reg.sv load/load_issue.sv store/store_issue.sv \
		store/store_table.sv source/mem_stage.sv

clean:
	rm -rf obj_dir
